/* ifetch_consts.svh */
`ifndef IFETCH_CONSTS_SVH
`define IFETCH_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// Fetch front end sizing
//////////////////////////////////////////////////////////////////////

// Address width, also the instruction word width
`define IFETCH_ADDR_W 32

// Log2 of words per line
// Four 32-bit words give a 128-bit line
`define IFETCH_OFFSET_W 2

// Decode buffer depth
// Also the credit count after reset
`define IFETCH_CREDITS 4

//////////////////////////////////////////////////////////////////////
// Boot
//////////////////////////////////////////////////////////////////////

// First PC out of reset
`define IFETCH_RESET_PC 32'h1c00_0000

`endif

/* ifetch_pkg.sv */
package ifetch_pkg;

    //////////////////////////////////////////////////////////////////////
    // Fetch engine FSM
    //////////////////////////////////////////////////////////////////////

    // Idle takes a request, req holds the address phase,
    // wait sits until the line comes back
    typedef enum logic [1:0] {
        DMA_IDLE = 2'd0,
        DMA_REQ  = 2'd1,
        DMA_WAIT = 2'd2
    } dma_state_e;

    //////////////////////////////////////////////////////////////////////
    // Memory bus access size
    //////////////////////////////////////////////////////////////////////

    // Encoding as seen on the memory bus size field
    // Fetch only ever issues word
    typedef enum logic [1:0] {
        MEM_BYTE = 2'd0,
        MEM_HALF = 2'd1,
        MEM_WORD = 2'd2
    } mem_size_e;

endpackage

/* fetch_req_if.sv */
`include "ifetch_consts.svh"

interface fetch_req_if;

    // Request side, one fetch at a time
    logic                          req_valid;
    logic [`IFETCH_ADDR_W-1:0]     req_addr;
    logic                          req_ready;

    // Response side
    // Single-cycle pulse, no ready, always taken by the controller
    logic                          resp_valid;
    // Low word is the requested address, high word the one after
    logic [2*`IFETCH_ADDR_W-1:0]   resp_pair;
    // High word present in the same line
    logic                          resp_second;

    // Controller view
    modport ctrl (
        output req_valid,
        output req_addr,
        input  req_ready,
        input  resp_valid,
        input  resp_pair,
        input  resp_second
    );

    // Fetch engine view
    modport dma (
        input  req_valid,
        input  req_addr,
        output req_ready,
        output resp_valid,
        output resp_pair,
        output resp_second
    );

endinterface

/* fetch_ctrl.sv */
`include "ifetch_consts.svh"

module fetch_ctrl (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          redirect,
    input  logic [`IFETCH_ADDR_W-1:0]     redirect_pc,
    input  logic                          credit_return,
    output logic                          fetch_valid,
    output logic [`IFETCH_ADDR_W-1:0]     fetch_pc,
    output logic [2*`IFETCH_ADDR_W-1:0]   fetch_pair,
    output logic                          fetch_second,
    fetch_req_if.ctrl                     bus
);

    localparam int ADDR_W   = `IFETCH_ADDR_W;
    localparam int CREDIT_W = $clog2(`IFETCH_CREDITS + 1);

    // Architectural fetch PC
    logic [ADDR_W-1:0]   pc;
    // One fetch sent to the engine, answer not yet back
    logic                outstanding;
    // Outstanding fetch belongs to the old path
    logic                stale;
    // Free slots in the decode buffer
    logic [CREDIT_W-1:0] credits;

    logic                req_fire;
    logic                resp_take;
    logic [ADDR_W-1:0]   pc_step;

    //////////////////////////////////////////////////////////////////////
    // Request to fetch engine
    //////////////////////////////////////////////////////////////////////

    // Need a free decode slot and an idle bus
    assign bus.req_valid = (credits != '0) && !outstanding;
    assign bus.req_addr  = pc;
    assign req_fire      = bus.req_valid && bus.req_ready;

    // Response goes to decode only if it is on the current path
    // A redirect in the same cycle kills it as well
    assign resp_take = bus.resp_valid && !stale && !redirect;

    // Two words consumed when the pair is full
    assign pc_step = bus.resp_second ? ADDR_W'(8) : ADDR_W'(4);

    //////////////////////////////////////////////////////////////////////
    // PC and in-flight tracking
    //////////////////////////////////////////////////////////////////////

    // Redirect wins over sequential advance
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pc <= `IFETCH_RESET_PC;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (resp_take) begin
            pc <= pc + pc_step;
        end
    end

    // Request and response never share a cycle
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            outstanding <= 1'b0;
        end else if (req_fire) begin
            outstanding <= 1'b1;
        end else if (bus.resp_valid) begin
            outstanding <= 1'b0;
        end
    end

    // Mark the in-flight fetch as wrong path
    // Includes a request leaving in the redirect cycle itself
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            stale <= 1'b0;
        end else if (bus.resp_valid) begin
            // Dropped or delivered, either way nothing left in flight
            stale <= 1'b0;
        end else if (redirect && (outstanding || req_fire)) begin
            stale <= 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Decode credits
    //////////////////////////////////////////////////////////////////////

    // Spend and return together cancel out
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            credits <= CREDIT_W'(`IFETCH_CREDITS);
        end else if (credit_return && !resp_take) begin
            credits <= credits + 1'b1;
        end else if (resp_take && !credit_return) begin
            credits <= credits - 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Output to decode
    //////////////////////////////////////////////////////////////////////

    // One cycle after the engine response
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            fetch_valid <= 1'b0;
        end else begin
            fetch_valid <= resp_take;
        end
    end

    // PC has not moved since the request, so it tags the pair
    always_ff @(posedge clk) begin
        if (resp_take) begin
            fetch_pc     <= pc;
            fetch_pair   <= bus.resp_pair;
            fetch_second <= bus.resp_second;
        end
    end

endmodule

/* icache_dma.sv */
`include "ifetch_consts.svh"

module icache_dma
    import ifetch_pkg::*;
(
    input  logic                                               clk,
    input  logic                                               rstn,
    fetch_req_if.dma                                           bus,
    output logic                                               mem_req,
    output logic [`IFETCH_ADDR_W-1:0]                          mem_addr,
    output mem_size_e                                          mem_size,
    input  logic                                               mem_addr_ok,
    input  logic                                               mem_data_ok,
    input  logic [(`IFETCH_ADDR_W << `IFETCH_OFFSET_W)-1:0]    mem_rdata
);

    localparam int ADDR_W   = `IFETCH_ADDR_W;
    localparam int OFFSET_W = `IFETCH_OFFSET_W;
    localparam int WORDS    = 1 << OFFSET_W;
    // Byte offset bits below the line boundary
    localparam int LINE_LSB = OFFSET_W + 2;

    dma_state_e state_q;
    dma_state_e state_d;

    // Word address of the pending fetch, byte bits dropped
    logic [ADDR_W-1:2]     addr_q;

    logic                  data_fire;
    logic [OFFSET_W-1:0]   offset;
    logic [OFFSET_W-1:0]   next_offset;
    logic                  last_word;
    logic [ADDR_W-1:0]     lo_word;
    logic [ADDR_W-1:0]     hi_word;

    logic                  resp_valid_q;
    logic [2*ADDR_W-1:0]   resp_pair_q;
    logic                  resp_second_q;

    //////////////////////////////////////////////////////////////////////
    // Bus FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state_q <= DMA_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Idle -> address phase -> data phase -> idle
    always_comb begin
        state_d = state_q;
        case (state_q)
            DMA_IDLE: begin
                if (bus.req_valid) begin
                    state_d = DMA_REQ;
                end
            end
            DMA_REQ: begin
                // Address held until memory takes it
                if (mem_addr_ok) begin
                    state_d = DMA_WAIT;
                end
            end
            DMA_WAIT: begin
                if (mem_data_ok) begin
                    state_d = DMA_IDLE;
                end
            end
            default: begin
                state_d = DMA_IDLE;
            end
        endcase
    end

    // Only accept work when the bus is free
    assign bus.req_ready = (state_q == DMA_IDLE);

    // Request starts the cycle after the accept
    assign mem_req  = (state_q == DMA_REQ);
    // Whole line, always aligned
    assign mem_addr = {addr_q[ADDR_W-1:LINE_LSB], {LINE_LSB{1'b0}}};
    assign mem_size = MEM_WORD;

    // Capture address on the request handshake
    always_ff @(posedge clk) begin
        if (bus.req_valid && bus.req_ready) begin
            addr_q <= bus.req_addr[ADDR_W-1:2];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Dual-word select
    //////////////////////////////////////////////////////////////////////

    assign data_fire   = (state_q == DMA_WAIT) && mem_data_ok;
    assign offset      = addr_q[LINE_LSB-1:2];
    // Wraps on the last word, masked below
    assign next_offset = OFFSET_W'(offset + 1'b1);
    assign last_word   = (offset == OFFSET_W'(WORDS - 1));

    // Word at the requested address
    assign lo_word = mem_rdata[offset*ADDR_W +: ADDR_W];
    // Following word, zero past the end of the line
    assign hi_word = last_word ? '0 : mem_rdata[next_offset*ADDR_W +: ADDR_W];

    //////////////////////////////////////////////////////////////////////
    // Response
    //////////////////////////////////////////////////////////////////////

    // Pulse one cycle after data
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            resp_valid_q <= 1'b0;
        end else begin
            resp_valid_q <= data_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (data_fire) begin
            resp_pair_q   <= {hi_word, lo_word};
            resp_second_q <= !last_word;
        end
    end

    assign bus.resp_valid  = resp_valid_q;
    assign bus.resp_pair   = resp_pair_q;
    assign bus.resp_second = resp_second_q;

endmodule

/* ifetch_top.sv */
`include "ifetch_consts.svh"

module ifetch_top (
    input  logic                                               clk,
    input  logic                                               rstn,

    // Branch redirect from the back end
    input  logic                                               redirect,
    input  logic [`IFETCH_ADDR_W-1:0]                          redirect_pc,

    // Decode side, credit based
    input  logic                                               credit_return,
    output logic                                               fetch_valid,
    output logic [`IFETCH_ADDR_W-1:0]                          fetch_pc,
    output logic [2*`IFETCH_ADDR_W-1:0]                        fetch_pair,
    output logic                                               fetch_second,

    // Instruction memory bus
    output logic                                               mem_req,
    output logic [`IFETCH_ADDR_W-1:0]                          mem_addr,
    // Size code, 2 is word
    output logic [1:0]                                         mem_size,
    input  logic                                               mem_addr_ok,
    input  logic                                               mem_data_ok,
    input  logic [(`IFETCH_ADDR_W << `IFETCH_OFFSET_W)-1:0]    mem_rdata
);

    //////////////////////////////////////////////////////////////////////
    // Controller to engine link
    //////////////////////////////////////////////////////////////////////

    fetch_req_if fetch_bus ();

    //////////////////////////////////////////////////////////////////////
    // PC, credits and redirect
    //////////////////////////////////////////////////////////////////////

    fetch_ctrl fetch_ctrl_inst (
        .clk           (clk),
        .rstn          (rstn),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc),
        .credit_return (credit_return),
        .fetch_valid   (fetch_valid),
        .fetch_pc      (fetch_pc),
        .fetch_pair    (fetch_pair),
        .fetch_second  (fetch_second),
        .bus           (fetch_bus.ctrl)
    );

    //////////////////////////////////////////////////////////////////////
    // Uncached line fetch
    //////////////////////////////////////////////////////////////////////

    // Enum size output lands on the plain 2-bit port
    icache_dma icache_dma_inst (
        .clk         (clk),
        .rstn        (rstn),
        .bus         (fetch_bus.dma),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_size    (mem_size),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok),
        .mem_rdata   (mem_rdata)
    );

endmodule

/* tb_inst_mem.sv */
`include "ifetch_consts.svh"

module tb_inst_mem
    import ifetch_pkg::*;
(
    input  logic                                               clk,
    input  logic                                               rstn,
    input  logic                                               mem_req,
    input  logic [`IFETCH_ADDR_W-1:0]                          mem_addr,
    input  logic [1:0]                                         mem_size,
    output logic                                               mem_addr_ok,
    output logic                                               mem_data_ok,
    output logic [(`IFETCH_ADDR_W << `IFETCH_OFFSET_W)-1:0]    mem_rdata
);

    localparam int ADDR_W = `IFETCH_ADDR_W;
    localparam int WORDS  = 1 << `IFETCH_OFFSET_W;
    localparam int LINE_W = ADDR_W * WORDS;
    // Content signature, word value is its byte address XOR this
    localparam logic [ADDR_W-1:0] WORD_XOR = 32'h5a5a_0000;

    integer            seed = 32'hc5af_b589;

    // Address phase delay running
    logic              armed;
    int                addr_wait;
    // Address taken, line on its way
    logic              busy;
    int                data_wait;
    logic [ADDR_W-1:0] line_addr;
    logic              word_size;

    // Whole line as the memory holds it
    function automatic logic [LINE_W-1:0] line_data(input logic [ADDR_W-1:0] base);
        logic [LINE_W-1:0] line;
        line = '0;
        for (int i = 0; i < WORDS; i++) begin
            line[i*ADDR_W +: ADDR_W] = (base + ADDR_W'(4 * i)) ^ WORD_XOR;
        end
        return line;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Two-phase bus responder
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mem_addr_ok <= 1'b0;
            mem_data_ok <= 1'b0;
            mem_rdata   <= '0;
            armed       <= 1'b0;
            addr_wait   <= 0;
            busy        <= 1'b0;
            data_wait   <= 0;
            line_addr   <= '0;
            word_size   <= 1'b0;
        end else begin
            // Data strobe is a single pulse
            mem_data_ok <= 1'b0;
            if (mem_addr_ok && mem_req) begin
                // Address handshake, start the data delay of 1 to 4
                mem_addr_ok <= 1'b0;
                line_addr   <= mem_addr;
                word_size   <= (mem_size == MEM_WORD);
                busy        <= 1'b1;
                data_wait   <= 1 + {$random(seed)} % 4;
            end else if (mem_req && !busy) begin
                if (!armed) begin
                    armed     <= 1'b1;
                    addr_wait <= {$random(seed)} % 4;
                end else if (addr_wait == 0) begin
                    mem_addr_ok <= 1'b1;
                    armed       <= 1'b0;
                end else begin
                    addr_wait <= addr_wait - 1;
                end
            end
            if (busy) begin
                if (data_wait == 1) begin
                    mem_data_ok <= 1'b1;
                    // Only word reads return the line
                    mem_rdata   <= word_size ? line_data(line_addr) : '0;
                    busy        <= 1'b0;
                end else begin
                    data_wait <= data_wait - 1;
                end
            end
        end
    end

endmodule

/* tb_ifetch.sv */
`include "ifetch_consts.svh"

module tb_ifetch
    import ifetch_pkg::*;
;

    localparam int ADDR_W     = `IFETCH_ADDR_W;
    localparam int LINE_W     = ADDR_W << `IFETCH_OFFSET_W;
    localparam int LINE_LSB   = `IFETCH_OFFSET_W + 2;
    localparam int NUM_PAIRS  = 200;
    // About 10 cycles per fetch plus credit stalls and redirects, then doubled
    localparam int MAX_CYCLES = NUM_PAIRS * 20;
    localparam logic [ADDR_W-1:0] WORD_XOR = 32'h5a5a_0000;

    logic              clk = 1'b0;
    logic              rstn = 1'b1;
    logic              redirect;
    logic [ADDR_W-1:0] redirect_pc;
    logic              credit_return;
    logic              fetch_valid;
    logic [ADDR_W-1:0] fetch_pc;
    logic [2*ADDR_W-1:0] fetch_pair;
    logic              fetch_second;
    logic              mem_req;
    logic [ADDR_W-1:0] mem_addr;
    logic [1:0]        mem_size;
    logic              mem_addr_ok;
    logic              mem_data_ok;
    logic [LINE_W-1:0] mem_rdata;

    integer            seed = 32'hc5af_b589;
    int                cycle_count = 0;
    int                pair_count;
    // Pairs sitting in the modeled decode buffer
    int                in_use;
    int                next_in_use;
    int                hold_cycles;
    logic [ADDR_W-1:0] exp_pc;
    logic              first_pending;
    // Address phase still open in the previous cycle
    logic              prev_wait;
    logic [ADDR_W-1:0] prev_addr;
    dma_state_e        eng_state;

    ifetch_top ifetch_top_inst (
        .clk           (clk),
        .rstn          (rstn),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc),
        .credit_return (credit_return),
        .fetch_valid   (fetch_valid),
        .fetch_pc      (fetch_pc),
        .fetch_pair    (fetch_pair),
        .fetch_second  (fetch_second),
        .mem_req       (mem_req),
        .mem_addr      (mem_addr),
        .mem_size      (mem_size),
        .mem_addr_ok   (mem_addr_ok),
        .mem_data_ok   (mem_data_ok),
        .mem_rdata     (mem_rdata)
    );

    tb_inst_mem tb_inst_mem_inst (
        .clk         (clk),
        .rstn        (rstn),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_size    (mem_size),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok),
        .mem_rdata   (mem_rdata)
    );

    // Engine state for the timeout report
    assign eng_state = ifetch_top_inst.icache_dma_inst.state_q;

    always #4 clk = ~clk;

    task automatic report_failure(input string msg);
        $display("[FAIL] %0t: %s", $time, msg);
        $display("Simulation failed");
        $fatal(1, "Stopping at first failed check");
    endtask

    //////////////////////////////////////////////////////////////////////
    // Decode credits and redirects
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (!rstn) begin
            credit_return <= 1'b0;
            redirect      <= 1'b0;
            redirect_pc   <= '0;
            hold_cycles   <= 0;
            in_use        <= 0;
        end else begin
            next_in_use = in_use + int'(fetch_valid) - int'(credit_return);
            in_use <= next_in_use;
            if (hold_cycles > 0) begin
                hold_cycles   <= hold_cycles - 1;
                credit_return <= 1'b0;
            end else if ({$random(seed)} % 160 == 0) begin
                // Long stall that drains every credit
                hold_cycles   <= 24 + {$random(seed)} % 48;
                credit_return <= 1'b0;
            end else if (next_in_use > 0 && {$random(seed)} % 2 == 0) begin
                credit_return <= 1'b1;
            end else begin
                credit_return <= 1'b0;
            end
            // Rare single-cycle redirect to a word-aligned PC
            if (!redirect && cycle_count > 40 && {$random(seed)} % 96 == 0) begin
                redirect    <= 1'b1;
                redirect_pc <= `IFETCH_RESET_PC + ({$random(seed)} & 32'h0000_fffc);
            end else begin
                redirect <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (!rstn) begin
            exp_pc        <= `IFETCH_RESET_PC;
            first_pending <= 1'b1;
            pair_count    <= 0;
            prev_wait     <= 1'b0;
            prev_addr     <= '0;
        end else begin
            if (fetch_valid) begin
                pair_count    <= pair_count + 1;
                first_pending <= 1'b0;
            end
            // A pair in the redirect cycle is still old path
            if (redirect) begin
                exp_pc        <= redirect_pc;
                first_pending <= 1'b0;
            end else if (fetch_valid) begin
                exp_pc <= fetch_pc + (fetch_second ? 32'd8 : 32'd4);
            end
            prev_wait <= mem_req && !mem_addr_ok;
            prev_addr <= mem_addr;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    first_pc_check: assert property (@(posedge clk) disable iff (!rstn)
        (fetch_valid && first_pending) |-> (fetch_pc == `IFETCH_RESET_PC))
        else report_failure("first fetch_pc is not the reset PC");

    path_check: assert property (@(posedge clk) disable iff (!rstn)
        fetch_valid |-> (fetch_pc == exp_pc))
        else report_failure("fetch_pc off the expected sequential or redirect path");

    low_word_check: assert property (@(posedge clk) disable iff (!rstn)
        fetch_valid |-> (fetch_pair[ADDR_W-1:0] == (fetch_pc ^ WORD_XOR)))
        else report_failure("low word of fetch_pair wrong for fetch_pc");

    second_flag_check: assert property (@(posedge clk) disable iff (!rstn)
        fetch_valid |-> (fetch_second == (fetch_pc[LINE_LSB-1:2] != '1)))
        else report_failure("fetch_second does not match position in line");

    high_word_check: assert property (@(posedge clk) disable iff (!rstn)
        (fetch_valid && fetch_second) |->
            (fetch_pair[2*ADDR_W-1:ADDR_W] == ((fetch_pc + 32'd4) ^ WORD_XOR)))
        else report_failure("high word of fetch_pair is not the next word");

    high_zero_check: assert property (@(posedge clk) disable iff (!rstn)
        (fetch_valid && !fetch_second) |-> (fetch_pair[2*ADDR_W-1:ADDR_W] == '0))
        else report_failure("high word not zero at end of line");

    credit_check: assert property (@(posedge clk) disable iff (!rstn)
        in_use <= `IFETCH_CREDITS)
        else report_failure("more pairs in flight to decode than credits");

    addr_hold_check: assert property (@(posedge clk) disable iff (!rstn)
        prev_wait |-> (mem_req && (mem_addr == prev_addr)))
        else report_failure("mem_req dropped or mem_addr moved before mem_addr_ok");

    align_check: assert property (@(posedge clk) disable iff (!rstn)
        mem_req |-> (mem_addr[LINE_LSB-1:0] == '0))
        else report_failure("mem_addr not line aligned");

    size_check: assert property (@(posedge clk) disable iff (!rstn)
        mem_req |-> (mem_size == MEM_WORD))
        else report_failure("mem_size is not word");

    reset_check: assert property (@(posedge clk)
        !rstn |-> (!fetch_valid && !mem_req))
        else report_failure("fetch_valid or mem_req high during reset");

    //////////////////////////////////////////////////////////////////////
    // Run control
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles with %0d of %0d pairs seen, engine in %s",
                     cycle_count, pair_count, NUM_PAIRS, eng_state.name());
            $display("Simulation failed");
            $fatal(1, "Run did not finish in time");
        end
    end

    initial begin
        rstn          <= 1'b0;
        redirect      = 1'b0;
        redirect_pc   = '0;
        credit_return = 1'b0;
        repeat (3) @(posedge clk);
        rstn <= 1'b1;
        wait (pair_count >= NUM_PAIRS);
        @(posedge clk);
        $display("Simulation passed");
        $finish;
    end

endmodule

/* ifetch.f */
+incdir+.
ifetch_pkg.sv
fetch_req_if.sv
fetch_ctrl.sv
icache_dma.sv
ifetch_top.sv
tb_inst_mem.sv
tb_ifetch.sv
